// ==== Makefile ====
TOP = tb_decode_stage

.PHONY: compile run clean

compile:
	verilator --binary --timing -sv --top-module $(TOP) -f verilog.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > run.log 2>&1 || true
	cat run.log
	grep -q "Test completed successfully" run.log

clean:
	rm -rf obj_dir run.log

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
  input logic active,
  input logic is_branch,
  input logic is_jump_register,
  input logic [5:0] branch_condition,
  input decode_pkg::data_t rs_value,
  input decode_pkg::data_t rt_value,
  input decode_pkg::data_t program_count,
  input decode_pkg::instruction_t instruction,
  output logic branch_taken,
  output decode_pkg::data_t branch_target
);
  import decode_pkg::*;

  logic rs_negative;
  logic rs_zero;
  logic operands_equal;
  logic condition_met;
  data_t sequential_pc;
  data_t branch_offset;

  assign rs_negative = rs_value[31];
  assign rs_zero = (rs_value == '0);
  assign operands_equal = (rs_value == rt_value);

  // same bit order as the decoder, eq at bit 0
  assign condition_met = |(branch_condition & {rs_negative,
                                               rs_negative | rs_zero,
                                               ~rs_negative & ~rs_zero,
                                               ~rs_negative,
                                               ~operands_equal,
                                               operands_equal});

  assign sequential_pc = program_count + 32'd4;
  assign branch_offset = {{14{instruction.i_view.immediate[15]}},
                          instruction.i_view.immediate, 2'b00};

  // no condition bit set means an unconditional jump
  assign branch_taken = active && is_branch && ((branch_condition == 6'd0) || condition_met);

  always_comb begin
    if (branch_condition != 6'd0) begin
      branch_target = sequential_pc + branch_offset;
    end else if (is_jump_register) begin
      branch_target = rs_value;
    end else begin
      branch_target = {sequential_pc[31:28], instruction.i_view[25:0], 2'b00};
    end
  end

endmodule

// ==== decode_pkg.sv ====
package decode_pkg;

  typedef logic [31:0] data_t;
  typedef logic [4:0] reg_index_t;

  typedef struct packed {
    logic [5:0] opcode;
    reg_index_t rs;
    reg_index_t rt;
    reg_index_t rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_view_t;

  // jump index is the low 26 bits of this view
  typedef struct packed {
    logic [5:0] opcode;
    reg_index_t rs;
    reg_index_t rt;
    logic [15:0] immediate;
  } i_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } instruction_t;

  // one-hot alu operation, bit positions
  typedef logic [11:0] alu_op_t;
  localparam int ALU_ADD = 0;
  localparam int ALU_SUB = 1;
  localparam int ALU_SLT = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND = 4;
  localparam int ALU_NOR = 5;
  localparam int ALU_OR = 6;
  localparam int ALU_XOR = 7;
  localparam int ALU_SLL = 8;
  localparam int ALU_SRL = 9;
  localparam int ALU_SRA = 10;
  localparam int ALU_LUI = 11;

  // one-hot access size
  typedef logic [2:0] mem_size_t;
  localparam int MEM_WORD = 0;
  localparam int MEM_HALF = 1;
  localparam int MEM_BYTE = 2;

  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_REGIMM = 6'h01;
  localparam logic [5:0] OP_J = 6'h02;
  localparam logic [5:0] OP_JAL = 6'h03;
  localparam logic [5:0] OP_BEQ = 6'h04;
  localparam logic [5:0] OP_BNE = 6'h05;
  localparam logic [5:0] OP_BLEZ = 6'h06;
  localparam logic [5:0] OP_BGTZ = 6'h07;
  localparam logic [5:0] OP_ADDI = 6'h08;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI = 6'h0a;
  localparam logic [5:0] OP_SLTIU = 6'h0b;
  localparam logic [5:0] OP_ANDI = 6'h0c;
  localparam logic [5:0] OP_ORI = 6'h0d;
  localparam logic [5:0] OP_XORI = 6'h0e;
  localparam logic [5:0] OP_LUI = 6'h0f;
  localparam logic [5:0] OP_LB = 6'h20;
  localparam logic [5:0] OP_LH = 6'h21;
  localparam logic [5:0] OP_LW = 6'h23;
  localparam logic [5:0] OP_LBU = 6'h24;
  localparam logic [5:0] OP_LHU = 6'h25;
  localparam logic [5:0] OP_SB = 6'h28;
  localparam logic [5:0] OP_SH = 6'h29;
  localparam logic [5:0] OP_SW = 6'h2b;

  localparam logic [5:0] FN_SLL = 6'h00;
  localparam logic [5:0] FN_SRL = 6'h02;
  localparam logic [5:0] FN_SRA = 6'h03;
  localparam logic [5:0] FN_SLLV = 6'h04;
  localparam logic [5:0] FN_SRLV = 6'h06;
  localparam logic [5:0] FN_SRAV = 6'h07;
  localparam logic [5:0] FN_JR = 6'h08;
  localparam logic [5:0] FN_JALR = 6'h09;
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR = 6'h25;
  localparam logic [5:0] FN_XOR = 6'h26;
  localparam logic [5:0] FN_NOR = 6'h27;
  localparam logic [5:0] FN_SLT = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

  localparam logic [4:0] RT_BLTZ = 5'h00;
  localparam logic [4:0] RT_BGEZ = 5'h01;

  localparam logic [4:0] LINK_REGISTER = 5'd31;

endpackage

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input logic clock,
  input logic reset,
  input logic if_valid,
  input decode_pkg::instruction_t if_instruction,
  input decode_pkg::data_t if_program_count,
  output logic id_allow_in,
  input logic ex_allow_in,
  output logic ex_valid,
  output decode_pkg::data_t ex_program_count,
  output decode_pkg::data_t ex_rs_value,
  output decode_pkg::data_t ex_rt_value,
  output logic [15:0] ex_immediate,
  output decode_pkg::reg_index_t ex_write_register,
  output decode_pkg::alu_op_t ex_alu_operation,
  output logic ex_source1_is_shift_amount,
  output logic ex_source1_is_program_count,
  output logic ex_source2_is_immediate,
  output logic ex_source2_is_unsigned,
  output logic ex_source2_is_8,
  output logic ex_register_write,
  output logic ex_memory_write,
  output logic ex_is_load,
  output decode_pkg::mem_size_t ex_memory_size,
  output logic ex_memory_unsigned,
  output logic ex_rt_is_source,
  output logic ex_is_jump_link,
  input logic ex_back_valid,
  input logic ex_back_data_valid,
  input decode_pkg::reg_index_t ex_back_register,
  input decode_pkg::data_t ex_back_data,
  input logic wb_write_enable,
  input decode_pkg::reg_index_t wb_write_register,
  input decode_pkg::data_t wb_write_data,
  output logic branch_taken,
  output decode_pkg::data_t branch_target
);
  import decode_pkg::*;

  logic id_valid;
  instruction_t held_instruction;
  data_t held_program_count;
  reg_index_t rs;
  reg_index_t rt;
  data_t rs_file_data;
  data_t rt_file_data;
  logic is_branch;
  logic is_jump_register;
  logic [5:0] branch_condition;
  logic stall;

  assign rs = held_instruction.r_view.rs;
  assign rt = held_instruction.r_view.rt;

  // branches need the final value even when ex already has it
  assign stall = ex_back_valid && (ex_back_register != 5'd0)
              && ((ex_back_register == rs) || (ex_rt_is_source && ex_back_register == rt))
              && (!ex_back_data_valid || is_branch);

  assign ex_valid = id_valid && !stall;
  assign id_allow_in = !id_valid || (!stall && ex_allow_in);

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (id_allow_in) begin
      id_valid <= if_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_valid && id_allow_in) begin
      held_instruction <= if_instruction;
      held_program_count <= if_program_count;
    end
  end

  assign ex_program_count = held_program_count;
  assign ex_immediate = held_instruction.i_view.immediate;

  register_file u_register_file (
    .clock(clock),
    .read_address_1(rs),
    .read_address_2(rt),
    .write_enable(wb_write_enable),
    .write_address(wb_write_register),
    .write_data(wb_write_data),
    .read_data_1(rs_file_data),
    .read_data_2(rt_file_data)
  );

  instruction_decoder u_instruction_decoder (
    .instruction(held_instruction),
    .alu_operation(ex_alu_operation),
    .source1_is_shift_amount(ex_source1_is_shift_amount),
    .source1_is_program_count(ex_source1_is_program_count),
    .source2_is_immediate(ex_source2_is_immediate),
    .source2_is_unsigned(ex_source2_is_unsigned),
    .source2_is_8(ex_source2_is_8),
    .register_write(ex_register_write),
    .memory_write(ex_memory_write),
    .is_load(ex_is_load),
    .memory_size(ex_memory_size),
    .memory_unsigned(ex_memory_unsigned),
    .write_register(ex_write_register),
    .rt_is_source(ex_rt_is_source),
    .is_branch(is_branch),
    .is_jump_register(is_jump_register),
    .is_jump_link(ex_is_jump_link),
    .branch_condition(branch_condition)
  );

  operand_forward u_forward_rs (
    .source_register(rs),
    .register_file_data(rs_file_data),
    .ex_back_valid(ex_back_valid),
    .ex_back_data_valid(ex_back_data_valid),
    .ex_back_register(ex_back_register),
    .ex_back_data(ex_back_data),
    .wb_write_enable(wb_write_enable),
    .wb_write_register(wb_write_register),
    .wb_write_data(wb_write_data),
    .operand(ex_rs_value)
  );

  operand_forward u_forward_rt (
    .source_register(rt),
    .register_file_data(rt_file_data),
    .ex_back_valid(ex_back_valid),
    .ex_back_data_valid(ex_back_data_valid),
    .ex_back_register(ex_back_register),
    .ex_back_data(ex_back_data),
    .wb_write_enable(wb_write_enable),
    .wb_write_register(wb_write_register),
    .wb_write_data(wb_write_data),
    .operand(ex_rt_value)
  );

  // redirect only once the operands are final
  branch_unit u_branch_unit (
    .active(ex_valid),
    .is_branch(is_branch),
    .is_jump_register(is_jump_register),
    .branch_condition(branch_condition),
    .rs_value(ex_rs_value),
    .rt_value(ex_rt_value),
    .program_count(held_program_count),
    .instruction(held_instruction),
    .branch_taken(branch_taken),
    .branch_target(branch_target)
  );

endmodule

// ==== decode_vectors.mem ====
// kind(0 preload 1 instr 2 load-use) instr pc back_ctl back_data wb_ctl wb_data
// exp_alu exp_flags(wr rw mw size taken) exp_rs exp_rt exp_target
0 00000000 00000000 0000 00000000 101 00000005 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 102 00000003 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 103 fffffff0 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 104 12345678 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 105 00000005 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 106 00000100 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 107 00000777 000 000000 00000000 00000000 00000000
0 00000000 00000000 0000 00000000 100 deadbeef 000 000000 00000000 00000000 00000000
1 00224020 00400000 0000 00000000 000 00000000 001 081000 00000005 00000003 00000000
1 00814822 00400004 0000 00000000 000 00000000 002 091000 12345678 00000005 00000000
1 0062502a 00400008 0000 00000000 000 00000000 004 0a1000 fffffff0 00000003 00000000
1 0062582b 0040000c 0000 00000000 000 00000000 008 0b1000 fffffff0 00000003 00000000
1 00866024 00400010 0000 00000000 000 00000000 010 0c1000 12345678 00000100 00000000
1 00226827 00400014 0000 00000000 000 00000000 020 0d1000 00000005 00000003 00000000
1 00027100 00400018 0000 00000000 000 00000000 100 0e1000 00000000 00000003 00000000
1 00267807 0040001c 0000 00000000 000 00000000 400 0f1000 00000005 00000100 00000000
1 24270010 00400020 0000 00000000 000 00000000 001 071000 00000005 00000777 00000000
1 3487ff00 00400024 0000 00000000 000 00000000 040 071000 12345678 00000777 00000000
1 3c061234 00400028 0000 00000000 000 00000000 800 061000 00000000 00000100 00000000
1 8cc70008 0040002c 0000 00000000 000 00000000 001 071010 00000100 00000777 00000000
1 9425fffe 00400030 0000 00000000 000 00000000 001 051020 00000005 00000005 00000000
1 a0440001 00400034 0000 00000000 000 00000000 001 000140 00000003 12345678 00000000
1 ac230000 00400038 0000 00000000 000 00000000 001 000110 00000005 fffffff0 00000000
1 fc000000 0040003c 0000 00000000 000 00000000 000 000000 00000000 00000000 00000000
1 00224020 00400040 1101 aaaa0001 101 bbbb0001 001 081000 aaaa0001 00000003 00000000
1 00224020 00400044 0000 00000000 102 cccc0002 001 081000 bbbb0001 cccc0002 00000000
2 00444820 00400048 1004 dddd0004 000 00000000 001 091000 cccc0002 dddd0004 00000000
1 10840010 0040004c 0000 00000000 000 00000000 000 000001 12345678 12345678 00400090
1 1484fffc 00400050 0000 00000000 000 00000000 000 1f0000 12345678 12345678 00000000
1 0460fff8 00400054 0000 00000000 000 00000000 000 1f0001 fffffff0 00000000 00400038
1 0461fff8 00400058 0000 00000000 000 00000000 000 1f0000 fffffff0 bbbb0001 00000000
1 1cc00004 0040005c 0000 00000000 000 00000000 000 000001 00000100 00000000 00400070
1 18c00004 00400060 0000 00000000 000 00000000 000 000000 00000100 00000000 00000000
1 08000040 00400064 0000 00000000 000 00000000 000 000001 00000000 00000000 00000100
1 0c000080 00400068 0000 00000000 000 00000000 001 1f1001 00000000 00000000 00000200
1 00c00008 0040006c 0000 00000000 000 00000000 000 000001 00000100 00000000 00000100
1 00e0f809 00400070 0000 00000000 000 00000000 001 1f1001 00000777 00000000 00000777

// ==== instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder (
  input decode_pkg::instruction_t instruction,
  output decode_pkg::alu_op_t alu_operation,
  output logic source1_is_shift_amount,
  output logic source1_is_program_count,
  output logic source2_is_immediate,
  output logic source2_is_unsigned,
  output logic source2_is_8,
  output logic register_write,
  output logic memory_write,
  output logic is_load,
  output decode_pkg::mem_size_t memory_size,
  output logic memory_unsigned,
  output decode_pkg::reg_index_t write_register,
  output logic rt_is_source,
  output logic is_branch,
  output logic is_jump_register,
  output logic is_jump_link,
  output logic [5:0] branch_condition
);
  import decode_pkg::*;

  wire [5:0] opcode = instruction.r_view.opcode;
  wire [5:0] funct = instruction.r_view.funct;
  wire reg_index_t rs = instruction.r_view.rs;
  wire reg_index_t rt = instruction.r_view.rt;
  wire reg_index_t rd = instruction.r_view.rd;
  wire rs_zero = (rs == 5'd0);
  wire rt_zero = (rt == 5'd0);
  wire rd_zero = (rd == 5'd0);
  wire shamt_zero = (instruction.r_view.shamt == 5'd0);

  wire special = (opcode == OP_SPECIAL);
  wire regimm = (opcode == OP_REGIMM);
  // register ops need shamt zero, immediate shifts need rs zero
  wire r_plain = special & shamt_zero;
  wire r_shift = special & rs_zero;

  wire i_add = r_plain & (funct == FN_ADD);
  wire i_addu = r_plain & (funct == FN_ADDU);
  wire i_sub = r_plain & (funct == FN_SUB);
  wire i_subu = r_plain & (funct == FN_SUBU);
  wire i_and = r_plain & (funct == FN_AND);
  wire i_or = r_plain & (funct == FN_OR);
  wire i_xor = r_plain & (funct == FN_XOR);
  wire i_nor = r_plain & (funct == FN_NOR);
  wire i_slt = r_plain & (funct == FN_SLT);
  wire i_sltu = r_plain & (funct == FN_SLTU);
  wire i_sll = r_shift & (funct == FN_SLL);
  wire i_srl = r_shift & (funct == FN_SRL);
  wire i_sra = r_shift & (funct == FN_SRA);
  wire i_sllv = r_plain & (funct == FN_SLLV);
  wire i_srlv = r_plain & (funct == FN_SRLV);
  wire i_srav = r_plain & (funct == FN_SRAV);
  wire i_jr = r_plain & (funct == FN_JR) & rt_zero & rd_zero;
  wire i_jalr = r_plain & (funct == FN_JALR) & rt_zero;

  wire i_addi = (opcode == OP_ADDI);
  wire i_addiu = (opcode == OP_ADDIU);
  wire i_andi = (opcode == OP_ANDI);
  wire i_ori = (opcode == OP_ORI);
  wire i_xori = (opcode == OP_XORI);
  wire i_slti = (opcode == OP_SLTI);
  wire i_sltiu = (opcode == OP_SLTIU);
  wire i_lui = (opcode == OP_LUI) & rs_zero;

  wire i_lb = (opcode == OP_LB);
  wire i_lbu = (opcode == OP_LBU);
  wire i_lh = (opcode == OP_LH);
  wire i_lhu = (opcode == OP_LHU);
  wire i_lw = (opcode == OP_LW);
  wire i_sb = (opcode == OP_SB);
  wire i_sh = (opcode == OP_SH);
  wire i_sw = (opcode == OP_SW);

  wire i_beq = (opcode == OP_BEQ);
  wire i_bne = (opcode == OP_BNE);
  wire i_blez = (opcode == OP_BLEZ) & rt_zero;
  wire i_bgtz = (opcode == OP_BGTZ) & rt_zero;
  wire i_bltz = regimm & (rt == RT_BLTZ);
  wire i_bgez = regimm & (rt == RT_BGEZ);
  wire i_j = (opcode == OP_J);
  wire i_jal = (opcode == OP_JAL);

  wire load_any = i_lb | i_lbu | i_lh | i_lhu | i_lw;
  wire store_any = i_sb | i_sh | i_sw;
  wire link = i_jal | i_jalr;
  wire immediate_alu = i_addi | i_addiu | i_andi | i_ori | i_xori | i_slti | i_sltiu;
  wire register_alu = i_add | i_addu | i_sub | i_subu | i_and | i_or | i_xor | i_nor
                    | i_slt | i_sltu | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;

  // link ops add 8 to the pc in execute
  assign alu_operation[ALU_ADD] = i_add | i_addu | i_addi | i_addiu | load_any | store_any | link;
  assign alu_operation[ALU_SUB] = i_sub | i_subu;
  assign alu_operation[ALU_SLT] = i_slt | i_slti;
  assign alu_operation[ALU_SLTU] = i_sltu | i_sltiu;
  assign alu_operation[ALU_AND] = i_and | i_andi;
  assign alu_operation[ALU_NOR] = i_nor;
  assign alu_operation[ALU_OR] = i_or | i_ori;
  assign alu_operation[ALU_XOR] = i_xor | i_xori;
  assign alu_operation[ALU_SLL] = i_sll | i_sllv;
  assign alu_operation[ALU_SRL] = i_srl | i_srlv;
  assign alu_operation[ALU_SRA] = i_sra | i_srav;
  assign alu_operation[ALU_LUI] = i_lui;

  assign source1_is_shift_amount = i_sll | i_srl | i_sra;
  assign source1_is_program_count = link;
  assign source2_is_immediate = immediate_alu | i_lui | load_any | store_any;
  assign source2_is_unsigned = i_andi | i_ori | i_xori;
  assign source2_is_8 = link;

  // every writing instruction has an alu op, stores are the only non-writers
  assign register_write = (|alu_operation) & ~store_any;
  assign memory_write = store_any;
  assign is_load = load_any;
  assign memory_size[MEM_WORD] = i_lw | i_sw;
  assign memory_size[MEM_HALF] = i_lh | i_lhu | i_sh;
  assign memory_size[MEM_BYTE] = i_lb | i_lbu | i_sb;
  assign memory_unsigned = i_lbu | i_lhu;

  assign write_register = link ? LINK_REGISTER
                        : (immediate_alu | i_lui | load_any) ? rt : rd;
  assign rt_is_source = register_alu | i_beq | i_bne | store_any;

  assign is_branch = i_beq | i_bne | i_bgez | i_bgtz | i_blez | i_bltz
                   | i_j | i_jal | i_jr | i_jalr;
  assign is_jump_register = i_jr | i_jalr;
  assign is_jump_link = link;
  // bit 0 eq up to bit 5 ltz
  assign branch_condition = {i_bltz, i_blez, i_bgtz, i_bgez, i_bne, i_beq};

endmodule

// ==== operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
  input decode_pkg::reg_index_t source_register,
  input decode_pkg::data_t register_file_data,
  input logic ex_back_valid,
  input logic ex_back_data_valid,
  input decode_pkg::reg_index_t ex_back_register,
  input decode_pkg::data_t ex_back_data,
  input logic wb_write_enable,
  input decode_pkg::reg_index_t wb_write_register,
  input decode_pkg::data_t wb_write_data,
  output decode_pkg::data_t operand
);

  logic source_nonzero;
  logic ex_hit;
  logic wb_hit;

  assign source_nonzero = (source_register != 5'd0);

  // a pending load result is not usable here, the stall covers that case
  assign ex_hit = source_nonzero && ex_back_valid && ex_back_data_valid
               && (ex_back_register == source_register);
  assign wb_hit = source_nonzero && wb_write_enable
               && (wb_write_register == source_register);

  always_comb begin
    if (ex_hit) begin
      operand = ex_back_data;
    end else if (wb_hit) begin
      operand = wb_write_data;
    end else begin
      operand = register_file_data;
    end
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input logic clock,
  input decode_pkg::reg_index_t read_address_1,
  input decode_pkg::reg_index_t read_address_2,
  input logic write_enable,
  input decode_pkg::reg_index_t write_address,
  input decode_pkg::data_t write_data,
  output decode_pkg::data_t read_data_1,
  output decode_pkg::data_t read_data_2
);
  import decode_pkg::*;

  data_t registers [32];

  always_ff @(posedge clock) begin
    if (write_enable && write_address != 5'd0) begin
      registers[write_address] <= write_data;
    end
  end

  // register 0 is never written, so force it on the read side
  assign read_data_1 = (read_address_1 == 5'd0) ? '0 : registers[read_address_1];
  assign read_data_2 = (read_address_2 == 5'd0) ? '0 : registers[read_address_2];

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  end

  // 4 ns period
  always #2 clock = ~clock;

endmodule

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;
  import decode_pkg::*;

  localparam int RECORD_WORDS = 12;
  localparam int MAX_RECORDS = 64;

  logic clock;
  logic reset;
  logic if_valid = 1'b0;
  instruction_t if_instruction = '0;
  data_t if_program_count = '0;
  logic ex_allow_in = 1'b0;
  logic ex_back_valid = 1'b0;
  logic ex_back_data_valid = 1'b0;
  reg_index_t ex_back_register = '0;
  data_t ex_back_data = '0;
  logic wb_write_enable = 1'b0;
  reg_index_t wb_write_register = '0;
  data_t wb_write_data = '0;

  logic id_allow_in;
  logic ex_valid;
  data_t ex_program_count;
  data_t ex_rs_value;
  data_t ex_rt_value;
  logic [15:0] ex_immediate;
  reg_index_t ex_write_register;
  alu_op_t ex_alu_operation;
  logic ex_source1_is_shift_amount;
  logic ex_source1_is_program_count;
  logic ex_source2_is_immediate;
  logic ex_source2_is_unsigned;
  logic ex_source2_is_8;
  logic ex_register_write;
  logic ex_memory_write;
  logic ex_is_load;
  mem_size_t ex_memory_size;
  logic ex_memory_unsigned;
  logic ex_rt_is_source;
  logic ex_is_jump_link;
  logic branch_taken;
  data_t branch_target;

  logic [31:0] vectors [MAX_RECORDS * RECORD_WORDS];
  logic [31:0] lfsr_state = 32'hc2f7_0cf9;
  int record_count = 0;
  int instruction_count = 0;
  int timeout_limit = 1000;
  int cycle_count = 0;
  int issue_index = 0;
  int held_index = -1;
  int held_cycles = 0;
  int checked_count = 0;
  int issued[$];
  logic presenting = 1'b0;
  logic accepted = 1'b0;
  logic left_decode = 1'b0;
  logic done = 1'b0;

  tb_clock_gen clock_gen (
    .clock(clock),
    .reset(reset)
  );

  decode_stage dut (.*);

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic random_bit();
    logic feedback;
    feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  function automatic logic [31:0] record_word(input int index, input int word);
    return vectors[index * RECORD_WORDS + word];
  endfunction

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_alu(input string name, input alu_op_t actual, input alu_op_t expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_register(input string name, input reg_index_t actual,
                                input reg_index_t expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_size(input string name, input mem_size_t actual,
                            input mem_size_t expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_immediate(input string name, input logic [15:0] actual,
                                 input logic [15:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  // flags word holds write register, register write, memory write, size, taken
  task automatic compare_outputs(input int index);
    logic [31:0] instruction_word;
    logic [31:0] alu_word;
    logic [31:0] flags;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic link;
    logic load;
    logic register_op;
    logic immediate_op;
    instruction_word = record_word(index, 1);
    alu_word = record_word(index, 7);
    flags = record_word(index, 8);
    opcode = instruction_word[31:26];
    funct = instruction_word[5:0];
    // jal and jalr link through pc plus 8
    link = (opcode == OP_JAL)
        || (opcode == OP_SPECIAL && funct == FN_JALR && alu_word[ALU_ADD]);
    // loads have a size and no memory write
    load = (flags[6:4] != 3'b000) && !flags[8];
    register_op = (opcode == OP_SPECIAL) && (alu_word[11:0] != 12'd0) && !link;
    immediate_op = (opcode != OP_SPECIAL) && (alu_word[11:0] != 12'd0) && !link;
    check_data("ex_program_count", ex_program_count, record_word(index, 2));
    check_alu("ex_alu_operation", ex_alu_operation, alu_word[11:0]);
    check_register("ex_write_register", ex_write_register, flags[20:16]);
    check_data("ex_rs_value", ex_rs_value, record_word(index, 9));
    check_data("ex_rt_value", ex_rt_value, record_word(index, 10));
    check_bit("ex_register_write", ex_register_write, flags[12]);
    check_bit("ex_memory_write", ex_memory_write, flags[8]);
    check_size("ex_memory_size", ex_memory_size, flags[6:4]);
    check_immediate("ex_immediate", ex_immediate, instruction_word[15:0]);
    // sll, srl and sra have funct bit 2 clear
    check_bit("ex_source1_is_shift_amount", ex_source1_is_shift_amount,
              register_op && !funct[2]
              && (alu_word[ALU_SLL] || alu_word[ALU_SRL] || alu_word[ALU_SRA]));
    check_bit("ex_source1_is_program_count", ex_source1_is_program_count, link);
    check_bit("ex_source2_is_immediate", ex_source2_is_immediate, immediate_op);
    // andi, ori and xori zero-extend
    check_bit("ex_source2_is_unsigned", ex_source2_is_unsigned,
              immediate_op && (alu_word[ALU_AND] || alu_word[ALU_OR] || alu_word[ALU_XOR]));
    check_bit("ex_source2_is_8", ex_source2_is_8, link);
    check_bit("ex_is_load", ex_is_load, load);
    // lbu and lhu have opcode bit 2 set
    check_bit("ex_memory_unsigned", ex_memory_unsigned, load && opcode[2]);
    check_bit("ex_rt_is_source", ex_rt_is_source,
              register_op || flags[8] || opcode == OP_BEQ || opcode == OP_BNE);
    check_bit("ex_is_jump_link", ex_is_jump_link, link);
    check_bit("branch_taken", branch_taken, flags[0]);
    if (flags[0]) begin
      check_data("branch_target", branch_target, record_word(index, 11));
    end
  endtask

  always @(negedge clock) begin
    accepted = !reset && if_valid && id_allow_in;
    left_decode = !reset && ex_valid && ex_allow_in;
    if (!reset && held_index >= 0 && record_word(held_index, 0) == 32'd2
        && !ex_back_data_valid) begin
      check_bit("ex_valid while load result pending", ex_valid, 1'b0);
    end
    if (!reset && ex_valid && !ex_allow_in) begin
      check_bit("id_allow_in under back-pressure", id_allow_in, 1'b0);
    end
    if (left_decode) begin
      if (issued.size() == 0) begin
        $display("decode presented an instruction that was never sent to it");
        stop_on_failure();
      end else begin
        compare_outputs(issued[0]);
        checked_count++;
      end
    end
  end

  always @(posedge clock) begin
    logic [31:0] back_control;
    logic [31:0] write_control;
    logic preload;
    logic allow_a;
    logic allow_b;
    if (!reset) begin
      cycle_count++;
      if (cycle_count >= timeout_limit) begin
        $display("timeout after %0d cycles with vectors still outstanding", cycle_count);
        stop_on_failure();
      end
      if (left_decode) begin
        void'(issued.pop_front());
        held_index = -1;
      end
      if (accepted) begin
        issued.push_back(issue_index);
        held_index = issue_index;
        held_cycles = 0;
        issue_index++;
        presenting = 1'b0;
      end else if (held_index >= 0) begin
        held_cycles++;
      end
      preload = 1'b0;
      if (!presenting && issue_index < record_count) begin
        // preloads only go out with the stage empty
        if (record_word(issue_index, 0) == 32'd0) begin
          preload = (held_index < 0);
        end else if (random_bit()) begin
          presenting = 1'b1;
          if_instruction <= record_word(issue_index, 1);
          if_program_count <= record_word(issue_index, 2);
        end
      end
      if_valid <= presenting;
      if (preload) begin
        write_control = record_word(issue_index, 5);
        wb_write_enable <= write_control[8];
        wb_write_register <= write_control[4:0];
        wb_write_data <= record_word(issue_index, 6);
        issue_index++;
      end else if (held_index >= 0) begin
        write_control = record_word(held_index, 5);
        wb_write_enable <= write_control[8];
        wb_write_register <= write_control[4:0];
        wb_write_data <= record_word(held_index, 6);
      end else begin
        wb_write_enable <= 1'b0;
        wb_write_register <= '0;
        wb_write_data <= '0;
      end
      if (held_index >= 0) begin
        back_control = record_word(held_index, 3);
        ex_back_valid <= back_control[12];
        // load result arrives after three held cycles
        ex_back_data_valid <= back_control[8]
                            || (record_word(held_index, 0) == 32'd2 && held_cycles >= 3);
        ex_back_register <= back_control[4:0];
        ex_back_data <= record_word(held_index, 4);
      end else begin
        ex_back_valid <= 1'b0;
        ex_back_data_valid <= 1'b0;
        ex_back_register <= '0;
        ex_back_data <= '0;
      end
      allow_a = random_bit();
      allow_b = random_bit();
      ex_allow_in <= allow_a | allow_b;
      if (issue_index == record_count && held_index < 0 && !presenting) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    int r;
    for (r = 0; r < MAX_RECORDS * RECORD_WORDS; r++) begin
      vectors[r] = ~32'(r);
    end
    $readmemh("decode_vectors.mem", vectors);
    while (record_count < MAX_RECORDS
           && record_word(record_count, 0) != ~32'(record_count * RECORD_WORDS)) begin
      if (record_word(record_count, 0) != 32'd0) begin
        instruction_count++;
      end
      record_count++;
    end
    timeout_limit = 40 * record_count;
    @(negedge clock);
    while (reset) begin
      @(negedge clock);
    end
    check_bit("id_allow_in after reset", id_allow_in, 1'b1);
    check_bit("ex_valid after reset", ex_valid, 1'b0);
    check_bit("branch_taken after reset", branch_taken, 1'b0);
    wait (done);
    @(negedge clock);
    if (checked_count != instruction_count) begin
      $display("only %0d of %0d instructions left decode", checked_count, instruction_count);
      stop_on_failure();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
decode_pkg.sv
register_file.sv
instruction_decoder.sv
operand_forward.sv
branch_unit.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv
